/* Bender.yml */
package:
  name: pngen

export_include_dirs:
  - logic

sources:
  - logic/pnGenPkg.sv
  - logic/pnGenRegs.sv
  - logic/pnRateNco.sv
  - logic/pnLfsr.sv
  - logic/pnErrorInject.sv
  - logic/pcmEncoder.sv
  - logic/pnGenTop.sv
  - target: test
    files:
      - dv/pnGenTb.sv

/* dv/pnGenTb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pnGen_config.svh"

module pnGenTb;
    import pnGenPkg::*;

    localparam logic [`PNGEN_ADDR_W-1:0] polyAddr = `PNGEN_BASE + `PNGEN_POLY;
    localparam logic [`PNGEN_ADDR_W-1:0] rateAddr = `PNGEN_BASE + `PNGEN_RATE;
    localparam logic [`PNGEN_ADDR_W-1:0] pcmAddr  = `PNGEN_BASE + `PNGEN_PCM_MODE;
    localparam logic [31:0] fastRate = 32'h2000_0000; // halfEn every 8 cycles

    localparam int bitCycles     = 16;
    localparam int flushCycles   = 4 * bitCycles;
    localparam int rateSettle    = 64;
    localparam int rateWindow    = 2048;
    localparam int seqBits       = 4 * 150 + 6 * 100;
    localparam int errBits       = 220 + 3 * `ERR_1E3_PERIOD + 10;
    localparam int rateCycles    = 5 * (rateSettle + rateWindow);
    localparam int timeoutCycles = 2 * ((seqBits + errBits) * bitCycles + rateCycles) + 20000;

    logic              busClk;
    logic              rst;
    busReq_t           busReq;
    logic [31:0]       rdData;
    fecCfg_t           fecCfg;
    logic              pcmData;
    logic              pcmStrobe;

    int   seed = 89;
    int   errCount = 0;
    int   checkCount = 0;
    int   cycleCount = 0;
    logic halves[$];     // half-symbols in arrival order
    logic modelBits[$];
    logic lineLevel;     // differential level of the reference encoder
    logic [31:0] curPoly;

    pnGenTop i_pnGenTop (
        .busClk    (busClk),
        .rst       (rst),
        .busReq    (busReq),
        .rdData    (rdData),
        .fecCfg    (fecCfg),
        .pcmData   (pcmData),
        .pcmStrobe (pcmStrobe)
    );

    initial begin
        busClk = 1'b0;
        forever #2 busClk = ~busClk;
    end

    always @(negedge busClk) begin
        if (!rst && pcmStrobe) begin
            halves.push_back(pcmData);
        end
    end

    initial begin
        while (cycleCount < timeoutCycles) begin
            @(posedge busClk);
            cycleCount++;
        end
        $display("run stopped by timeout after %0d cycles", cycleCount);
        $display("sim failed");
        $finish;
    end

    task automatic compareValue(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            $display("Mismatch %s exp %h got %h", name, exp, got);
        end
    endtask

    task automatic applyReset;
        @(negedge busClk);
        rst = 1'b1;
        busReq = '0;
        repeat (2) @(negedge busClk);
        rst = 1'b0;
        lineLevel = 1'b0;
    endtask

    task automatic writeReg(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] we);
        @(negedge busClk);
        busReq.addr = addr;
        busReq.wrData = data;
        busReq.byteWe = we;
        @(negedge busClk);
        busReq.byteWe = '0;
    endtask

    task automatic readReg(input logic [12:0] addr, output logic [31:0] data);
        @(negedge busClk);
        busReq.addr = addr;
        busReq.byteWe = '0;
        @(posedge busClk);
        data = rdData;
    endtask

    function automatic logic [31:0] mergeLanes(logic [31:0] old, logic [31:0] data,
                                               logic [3:0] we, logic [31:0] keep);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                res[8*i +: 8] = data[8*i +: 8] & keep[8*i +: 8];
            end
        end
        return res;
    endfunction

    // one shift of an LFSR of the given order
    function automatic logic [23:0] lfsrAdvance(logic [23:0] st, logic [23:0] taps,
                                                int order, logic gal);
        logic [23:0] nxt;
        logic        top;
        logic        fb;
        nxt = '0;
        top = st[order-1];
        fb  = 1'b0;
        if (!gal) begin
            for (int i = 0; i < order; i++) begin
                if (taps[i]) begin
                    fb = fb ^ st[i];
                end
            end
            for (int i = order - 1; i > 0; i--) begin
                nxt[i] = st[i-1];
            end
            nxt[0] = fb;
        end else begin
            for (int i = order - 1; i > 0; i--) begin
                nxt[i] = st[i-1] ^ (top & taps[i]); // galois feedback into taps
            end
            nxt[0] = top & taps[0];
        end
        return nxt;
    endfunction

    task automatic buildModel(input logic [23:0] taps, input int order, input logic gal,
                              input int n);
        logic [23:0] st;
        st = '1;
        modelBits.delete();
        for (int i = 0; i < n; i++) begin
            modelBits.push_back(st[order-1]);
            st = lfsrAdvance(st, taps, order, gal);
        end
    endtask

    task automatic compareHalves(input logic [3:0] code, input logic inv);
        logic b;
        logic expA;
        logic expB;
        for (int i = 0; i < modelBits.size(); i++) begin
            b = modelBits[i];
            expA = b;
            expB = b;
            if (code == NRZM) begin
                lineLevel = lineLevel ^ b;
                expA = lineLevel;
                expB = lineLevel;
            end else if (code == NRZS) begin
                lineLevel = lineLevel ^ ~b;
                expA = lineLevel;
                expB = lineLevel;
            end else if (code == BIPHL) begin
                expB = ~b;
            end
            compareValue($sformatf("pcmData bit %0d first half", i),
                         32'(expA ^ inv), 32'(halves[2*i]));
            compareValue($sformatf("pcmData bit %0d second half", i),
                         32'(expB ^ inv), 32'(halves[2*i+1]));
        end
    endtask

    // load config with restart held, drain the line, then release
    task automatic startPattern(input logic [23:0] taps, input int order, input logic gal,
                                input logic [3:0] code, input logic inv);
        curPoly = {gal, 1'b1, 1'b0, 5'(order - 1), taps};
        writeReg(polyAddr, curPoly, 4'hF);
        writeReg(pcmAddr, {24'b0, inv, 3'b000, code}, 4'b0011);
        repeat (flushCycles) @(posedge busClk);
        halves.delete();
        curPoly[`PNGEN_RESTART_BIT] = 1'b0;
        writeReg(polyAddr, curPoly, 4'b1000);
    endtask

    task automatic stopPattern;
        curPoly[`PNGEN_RESTART_BIT] = 1'b1;
        writeReg(polyAddr, curPoly, 4'b1000);
        repeat (flushCycles) @(posedge busClk);
    endtask

    task automatic waitBits(input int n);
        while (halves.size() < 2 * n) begin
            @(posedge busClk);
        end
    endtask

    task automatic registerTest;
        logic [31:0] shadow [3];
        logic [31:0] keep [3];
        logic [12:0] addrs [3];
        logic [31:0] data;
        logic [31:0] got;
        logic [3:0]  we;
        int          sel;
        shadow = '{default: '0};
        keep = '{32'hDFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_FFEF}; // reserved bits cleared
        addrs = '{polyAddr, rateAddr, pcmAddr};
        for (int n = 0; n < 60; n++) begin
            sel = $unsigned($random(seed)) % 3;
            data = $random(seed);
            we = $random(seed);
            writeReg(addrs[sel], data, we);
            shadow[sel] = mergeLanes(shadow[sel], data, we, keep[sel]);
            for (int r = 0; r < 3; r++) begin
                readReg(addrs[r], got);
                compareValue($sformatf("rdData @%h", addrs[r]), shadow[r], got);
            end
            compareValue("fecCfg", {24'b0, shadow[2][9:8], shadow[2][10], shadow[2][6:5],
                         shadow[2][11], shadow[2][13:12]}, 32'(fecCfg));
        end
        // writes outside the mapped registers land nowhere
        writeReg(`PNGEN_BASE + 13'h00C, 32'hFFFF_FFFF, 4'hF);
        writeReg(`PNGEN_BASE + 13'h010, 32'hFFFF_FFFF, 4'hF);
        writeReg(13'h0000, 32'hFFFF_FFFF, 4'hF);
        for (int r = 0; r < 3; r++) begin
            readReg(addrs[r], got);
            compareValue($sformatf("rdData @%h", addrs[r]), shadow[r], got);
        end
        readReg(`PNGEN_BASE + 13'h00C, got);
        compareValue("rdData @10c", 32'h0, got);
        readReg(13'h0000, got);
        compareValue("rdData @000", 32'h0, got);
        readReg(13'h0110, got);
        compareValue("rdData @110", 32'h0, got);
        readReg(13'h1F04, got);
        compareValue("rdData @1f04", 32'h0, got);
    endtask

    task automatic runSequence(input logic [23:0] taps, input int order, input logic gal,
                               input logic [3:0] code, input logic inv, input int nBits);
        startPattern(taps, order, gal, code, inv);
        waitBits(nBits);
        stopPattern();
        checkCount++;
        assert (halves.size() >= 2 * nBits && halves.size() % 2 == 0) else begin
            errCount++;
            $display("pattern run ended with %0d half-symbols, wanted an even count of %0d",
                     halves.size(), 2 * nBits);
        end
        buildModel(taps, order, gal, halves.size() / 2);
        compareHalves(code, inv);
    endtask

    task automatic rateTest;
        logic [31:0] rates [5];
        longint      expStrobes;
        int          got;
        int          n0;
        rates = '{32'h2000_0000, 32'h1000_0000, 32'h0C00_0000, 32'h0555_5555, 32'h0};
        startPattern(24'h60, 7, 1'b0, NRZL, 1'b0);
        foreach (rates[k]) begin
            writeReg(rateAddr, rates[k], 4'hF);
            repeat (rateSettle) @(posedge busClk);
            n0 = halves.size();
            repeat (rateWindow) @(posedge busClk);
            got = halves.size() - n0;
            expStrobes = 2 * ((longint'(rateWindow) * rates[k]) >> 33); // two per bit
            checkCount++;
            assert (got >= expStrobes - 2 && got <= expStrobes + 2) else begin
                errCount++;
                $display("Mismatch pcmStrobe count exp %h got %h", expStrobes, got);
            end
        end
        writeReg(rateAddr, fastRate, 4'hF);
        stopPattern();
    endtask

    task automatic errorTest;
        int bitsAtSet;
        int firstFlip;
        int oneFlips;
        int nBits;
        startPattern(24'h6000, 15, 1'b0, NRZL, 1'b0);
        waitBits(40);
        writeReg(pcmAddr, 32'h0000_8000, 4'b0010); // injectOne edge
        waitBits(80);
        writeReg(pcmAddr, 32'h0, 4'b0010);
        waitBits(100);
        writeReg(pcmAddr, 32'h0000_4000, 4'b0010);
        @(posedge busClk);
        bitsAtSet = halves.size() / 2;
        waitBits(bitsAtSet + 3 * `ERR_1E3_PERIOD + 10);
        stopPattern();
        writeReg(pcmAddr, 32'h0, 4'b0010);
        nBits = halves.size() / 2;
        buildModel(24'h6000, 15, 1'b0, nBits);
        oneFlips = 0;
        firstFlip = -1;
        for (int i = 0; i < nBits; i++) begin
            if (halves[2*i] !== modelBits[i]) begin
                if (i < bitsAtSet) begin
                    oneFlips++;
                    modelBits[i] = ~modelBits[i];
                end else if (firstFlip < 0) begin
                    firstFlip = i;
                end
            end
        end
        checkCount++;
        assert (oneFlips == 1) else begin
            errCount++;
            $display("single injection inverted %0d bits instead of one", oneFlips);
        end
        checkCount++;
        assert (firstFlip >= bitsAtSet + `ERR_1E3_PERIOD - 2 &&
                firstFlip <= bitsAtSet + `ERR_1E3_PERIOD + 1) else begin
            errCount++;
            $display("first 1e-3 error at bit %0d, setting was at bit %0d",
                     firstFlip, bitsAtSet);
        end
        // every thousandth bit from the first one, nothing in between
        for (int i = bitsAtSet; i < nBits; i++) begin
            if (firstFlip >= 0 && i >= firstFlip && (i - firstFlip) % `ERR_1E3_PERIOD == 0) begin
                modelBits[i] = ~modelBits[i];
            end
        end
        compareHalves(NRZL, 1'b0);
    endtask

    initial begin
        rst = 1'b1;
        busReq = '0;
        lineLevel = 1'b0;
        curPoly = '0;
        applyReset();
        @(posedge busClk);
        compareValue("pcmStrobe", 32'h0, 32'(pcmStrobe));
        compareValue("pcmData", 32'h0, 32'(pcmData));

        registerTest();
        applyReset(); // clears whatever the random writes started

        writeReg(rateAddr, fastRate, 4'hF);
        runSequence(24'h000060, 7, 1'b0, NRZL, 1'b0, 150);
        runSequence(24'h006000, 15, 1'b0, NRZL, 1'b0, 150);
        runSequence(24'h000041, 7, 1'b1, NRZL, 1'b0, 150);  // same polys, galois taps
        runSequence(24'h004001, 15, 1'b1, NRZL, 1'b0, 150);

        for (int c = 1; c <= 3; c++) begin
            for (int v = 0; v < 2; v++) begin
                runSequence(24'h000060, 7, 1'b0, 4'(c), 1'(v), 100);
            end
        end

        rateTest();
        errorTest();

        $display("errors %0d in %0d checks", errCount, checkCount);
        if (errCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/pcmEncoder.sv */
`timescale 1ns/10ps
`default_nettype none

module pcmEncoder (
    input  wire  pnGenPkg::pcmCfg_t cfg,
    input  wire                     busClk,
    input  wire                     rst,
    input  wire                     bitIn,
    input  wire                     bitValid,
    input  wire                     halfEn,
    output logic                    pcmData,
    output logic                    pcmStrobe
);
    import pnGenPkg::*;

    logic level;       // differential line state
    logic nextLevel;
    logic firstHalf;
    logic secondHalf;
    logic secondBit;
    logic pending;

    always_comb begin
        nextLevel  = level;
        firstHalf  = bitIn;
        secondHalf = bitIn;
        case (cfg.code)
            NRZM: begin
                nextLevel  = level ^ bitIn;   // transition on one
                firstHalf  = nextLevel;
                secondHalf = nextLevel;
            end
            NRZS: begin
                nextLevel  = level ^ ~bitIn;  // transition on zero
                firstHalf  = nextLevel;
                secondHalf = nextLevel;
            end
            BIPHL: begin
                secondHalf = ~bitIn;
            end
            default: ;
        endcase
    end

    always_ff @(posedge busClk) begin
        if (rst) begin
            level     <= 1'b0;
            pending   <= 1'b0;
            secondBit <= 1'b0;
            pcmData   <= 1'b0;
            pcmStrobe <= 1'b0;
        end else begin
            pcmStrobe <= 1'b0;
            if (bitValid) begin
                level     <= nextLevel;
                pcmData   <= firstHalf ^ cfg.invert;
                pcmStrobe <= 1'b1;
                secondBit <= secondHalf;
                pending   <= 1'b1;
            end else if (halfEn && pending) begin
                // second half of the symbol
                pcmData   <= secondBit ^ cfg.invert;
                pcmStrobe <= 1'b1;
                pending   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pnErrorInject.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pnGen_config.svh"

module pnErrorInject (
    input  wire  pnGenPkg::errCfg_t cfg,
    input  wire                     busClk,
    input  wire                     rst,
    input  wire                     pnBit,
    input  wire                     pnValid,
    output logic                    errBit,
    output logic                    errValid
);

    localparam int cntW = $clog2(`ERR_1E3_PERIOD);

    logic [cntW-1:0] bitCnt;
    logic            injPrev;
    logic            armed;
    logic            oneEdge;
    logic            hit;
    logic            flip;

    assign oneEdge = cfg.injectOne & ~injPrev;
    assign hit     = cfg.inject1E3 && (bitCnt == cntW'(`ERR_1E3_PERIOD - 1));
    assign flip    = pnValid & (armed | oneEdge | hit);

    always_ff @(posedge busClk) begin
        if (rst) begin
            injPrev  <= 1'b0;
            armed    <= 1'b0;
            bitCnt   <= '0;
            errValid <= 1'b0;
        end else begin
            injPrev  <= cfg.injectOne;
            errValid <= pnValid;

            // one-shot consumed by the next valid bit
            if (pnValid) begin
                armed <= 1'b0;
            end else if (oneEdge) begin
                armed <= 1'b1;
            end

            if (!cfg.inject1E3) begin
                bitCnt <= '0;
            end else if (pnValid) begin
                bitCnt <= hit ? '0 : bitCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (pnValid) begin
            errBit <= pnBit ^ flip;
        end
    end

endmodule

`default_nettype wire

/* logic/pnGenPkg.sv */
`default_nettype none
`include "pnGen_config.svh"

package pnGenPkg;

    typedef struct packed {
        logic [`PNGEN_ADDR_W-1:0]   addr;
        logic [`PNGEN_DATA_W-1:0]   wrData;
        logic [`PNGEN_DATA_W/8-1:0] byteWe; // one per byte lane
    } busReq_t;

    typedef struct packed {
        logic [`PN_MAX_LEN-1:0] taps;
        logic [`PN_LEN_W-1:0]   length;  // order minus one
        logic                   galois;  // 0 = fibonacci
        logic                   restart;
    } pnCfg_t;

    // undefined codes fall back to NRZ-L
    typedef enum logic [`PCM_CODE_W-1:0] {
        NRZL  = 4'd0,
        NRZM  = 4'd1,
        NRZS  = 4'd2,
        BIPHL = 4'd3
    } pcmCode_t;

    typedef struct packed {
        pcmCode_t code;
        logic     invert;
    } pcmCfg_t;

    typedef struct packed {
        logic inject1E3;
        logic injectOne;
    } errCfg_t;

    // stored only, consumed by an external FEC encoder
    typedef struct packed {
        logic [1:0] fecMode;
        logic       vitG2Inv;
        logic [1:0] ldpcRate;
        logic       ldpcBlockSize;
        logic [1:0] ldpcRandomize;
    } fecCfg_t;

endpackage

`default_nettype wire

/* logic/pnGenRegs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pnGen_config.svh"

module pnGenRegs (
    input  wire  pnGenPkg::busReq_t      busReq,
    input  wire                          busClk,
    input  wire                          rst,
    output logic [`PNGEN_DATA_W-1:0]     rdData,
    output pnGenPkg::pnCfg_t             pnCfg,
    output pnGenPkg::pcmCfg_t            pcmCfg,
    output pnGenPkg::errCfg_t            errCfg,
    output pnGenPkg::fecCfg_t            fecCfg,
    output logic [31:0]                  rate
);
    import pnGenPkg::*;

    localparam logic [`PNGEN_ADDR_W-1:0] regBase = `PNGEN_BASE;

    logic                          inWindow;
    logic [3:0]                    offset;
    logic [`PNGEN_DATA_W-1:0]      wd;
    logic [`PNGEN_DATA_W/8-1:0]    we;

    // window from upper bits, register from low nibble
    assign inWindow = busReq.addr[`PNGEN_ADDR_W-1:4] == regBase[`PNGEN_ADDR_W-1:4];
    assign offset   = busReq.addr[3:0];
    assign wd       = busReq.wrData;
    assign we       = busReq.byteWe;

    always_ff @(posedge busClk) begin
        if (rst) begin
            pnCfg  <= '0;
            pcmCfg <= '0;
            errCfg <= '0;
            fecCfg <= '0;
            rate   <= '0;
        end else if (inWindow) begin
            case (offset)
                `PNGEN_POLY: begin
                    if (we[0]) pnCfg.taps[7:0]   <= wd[7:0];
                    if (we[1]) pnCfg.taps[15:8]  <= wd[15:8];
                    if (we[2]) pnCfg.taps[23:16] <= wd[23:16];
                    if (we[3]) begin
                        pnCfg.length  <= wd[`PNGEN_LEN_LSB +: `PN_LEN_W];
                        pnCfg.restart <= wd[`PNGEN_RESTART_BIT];
                        pnCfg.galois  <= wd[`PNGEN_GALOIS_BIT];
                    end
                end
                `PNGEN_RATE: begin
                    for (int i = 0; i < 4; i++) begin
                        if (we[i]) rate[8*i +: 8] <= wd[8*i +: 8];
                    end
                end
                `PNGEN_PCM_MODE: begin
                    if (we[0]) begin
                        pcmCfg.code     <= pcmCode_t'(wd[`PCM_CODE_W-1:0]);
                        fecCfg.ldpcRate <= wd[6:5];
                        pcmCfg.invert   <= wd[7];
                    end
                    if (we[1]) begin
                        fecCfg.fecMode       <= wd[9:8];
                        fecCfg.vitG2Inv      <= wd[10];
                        fecCfg.ldpcBlockSize <= wd[11];
                        fecCfg.ldpcRandomize <= wd[13:12];
                        errCfg.inject1E3     <= wd[14];
                        errCfg.injectOne     <= wd[15];
                    end
                    // upper two lanes are reserved
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        rdData = '0;
        if (inWindow) begin
            case (offset)
                `PNGEN_POLY: begin
                    rdData = {pnCfg.galois, pnCfg.restart, 1'b0, pnCfg.length, pnCfg.taps};
                end
                `PNGEN_RATE: begin
                    rdData = rate;
                end
                `PNGEN_PCM_MODE: begin
                    rdData = {16'b0,
                              errCfg.injectOne,
                              errCfg.inject1E3,
                              fecCfg.ldpcRandomize,
                              fecCfg.ldpcBlockSize,
                              fecCfg.vitG2Inv,
                              fecCfg.fecMode,
                              pcmCfg.invert,
                              fecCfg.ldpcRate,
                              1'b0,
                              pcmCfg.code};
                end
                default: rdData = '0; // 0xC unmapped
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/pnGenTop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pnGen_config.svh"

module pnGenTop (
    input  wire  pnGenPkg::busReq_t   busReq,
    input  wire                       busClk,
    input  wire                       rst,
    output logic [`PNGEN_DATA_W-1:0]  rdData,
    output pnGenPkg::fecCfg_t         fecCfg,
    output logic                      pcmData,
    output logic                      pcmStrobe
);
    import pnGenPkg::*;

    pnCfg_t      pnCfg;
    pcmCfg_t     pcmCfg;
    errCfg_t     errCfg;
    logic [31:0] rate;
    logic        halfEn;
    logic        bitEn;
    logic        pnBit;
    logic        pnValid;
    logic        errBit;
    logic        errValid;

    pnGenRegs i_pnGenRegs (
        .busClk (busClk),
        .rst    (rst),
        .busReq (busReq),
        .rdData (rdData),
        .pnCfg  (pnCfg),
        .pcmCfg (pcmCfg),
        .errCfg (errCfg),
        .fecCfg (fecCfg),
        .rate   (rate)
    );

    pnRateNco i_pnRateNco (
        .busClk (busClk),
        .rst    (rst),
        .rate   (rate),
        .halfEn (halfEn),
        .bitEn  (bitEn)
    );

    pnLfsr i_pnLfsr (
        .busClk  (busClk),
        .rst     (rst),
        .cfg     (pnCfg),
        .bitEn   (bitEn),
        .pnBit   (pnBit),
        .pnValid (pnValid)
    );

    pnErrorInject i_pnErrorInject (
        .busClk   (busClk),
        .rst      (rst),
        .cfg      (errCfg),
        .pnBit    (pnBit),
        .pnValid  (pnValid),
        .errBit   (errBit),
        .errValid (errValid)
    );

    pcmEncoder i_pcmEncoder (
        .busClk    (busClk),
        .rst       (rst),
        .cfg       (pcmCfg),
        .bitIn     (errBit),
        .bitValid  (errValid),
        .halfEn    (halfEn),
        .pcmData   (pcmData),
        .pcmStrobe (pcmStrobe)
    );

endmodule

`default_nettype wire

/* logic/pnGen_config.svh */
`ifndef PNGEN_CONFIG_SVH
`define PNGEN_CONFIG_SVH

// bus geometry
`define PNGEN_ADDR_W        13
`define PNGEN_DATA_W        32

// 16-byte register window
`define PNGEN_BASE          13'h0100
`define PNGEN_POLY          4'h0
`define PNGEN_RATE          4'h4
`define PNGEN_PCM_MODE      4'h8

// POLY register fields
`define PN_MAX_LEN          24
`define PN_LEN_W            5
`define PNGEN_LEN_LSB       24
`define PNGEN_RESTART_BIT   30
`define PNGEN_GALOIS_BIT    31

// PCM_MODE register fields
`define PCM_CODE_W          4

// bits per injected error in 1e-3 mode
`define ERR_1E3_PERIOD      1000

`endif

/* logic/pnLfsr.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pnGen_config.svh"

module pnLfsr (
    input  wire  pnGenPkg::pnCfg_t cfg,
    input  wire                    busClk,
    input  wire                    rst,
    input  wire                    bitEn,
    output logic                   pnBit,
    output logic                   pnValid
);

    localparam int lfsrW = `PN_MAX_LEN;

    logic [lfsrW-1:0] state;
    logic [lfsrW-1:0] mask;
    logic [lfsrW-1:0] nextFib;
    logic [lfsrW-1:0] nextGal;
    logic [4:0]       topIdx;
    logic             outBit;
    logic             fbBit;

    // taps bit i selects state bit i in both forms
    always_comb begin
        topIdx = (cfg.length > 5'(lfsrW - 1)) ? 5'(lfsrW - 1) : cfg.length;
        mask   = ~({lfsrW{1'b1}} << (topIdx + 5'd1));
        outBit = state[topIdx];

        // fibonacci: parity of tapped bits enters at bit 0
        fbBit   = ^(state & cfg.taps & mask);
        nextFib = ((state << 1) | lfsrW'(fbBit)) & mask;

        // galois: outgoing bit xored into tapped positions
        nextGal = ((state << 1) ^ ({lfsrW{outBit}} & cfg.taps)) & mask;
    end

    always_ff @(posedge busClk) begin
        if (rst || cfg.restart) begin
            state   <= '1;  // seed
            pnValid <= 1'b0;
        end else begin
            pnValid <= bitEn;
            if (bitEn) begin
                state <= cfg.galois ? nextGal : nextFib;
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (bitEn) begin
            pnBit <= outBit;
        end
    end

endmodule

`default_nettype wire

/* logic/pnRateNco.sv */
`timescale 1ns/10ps
`default_nettype none

module pnRateNco (
    input  wire         busClk,
    input  wire         rst,
    input  wire  [31:0] rate,
    output logic        halfEn,
    output logic        bitEn
);

    logic [31:0] phase;
    logic [32:0] sum;
    logic        bitPhase; // high between first and second half

    assign sum = {1'b0, phase} + {1'b0, rate};

    always_ff @(posedge busClk) begin
        if (rst) begin
            phase    <= '0;
            halfEn   <= 1'b0;
            bitPhase <= 1'b0;
        end else begin
            phase  <= sum[31:0];
            halfEn <= sum[32];      // carry out, one cycle late
            if (halfEn) begin
                bitPhase <= ~bitPhase;
            end
        end
    end

    // every second half-bit strobe, starting with the second
    assign bitEn = halfEn & bitPhase;

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/pnGenPkg.sv
logic/pnGenRegs.sv
logic/pnRateNco.sv
logic/pnLfsr.sv
logic/pnErrorInject.sv
logic/pcmEncoder.sv
logic/pnGenTop.sv
dv/pnGenTb.sv
